//--- hw/schedPkg.sv
package schedPkg;

	// Cluster size
	localparam int numCores = 4;
	localparam int r0Width = 4;

	// Frame store geometry
	localparam int frameWidth = 32;
	localparam int memDepth = 16;
	localparam int memAddrWidth = 4;
	localparam int frameCountWidth = memAddrWidth + 1;	// Counts 1 to memDepth

	// APB register map
	localparam int apbAddrWidth = 8;
	localparam logic [apbAddrWidth-1:0] ctrlAddr = 8'h40;
	localparam logic [apbAddrWidth-1:0] statusAddr = 8'h44;

	// Fence codes carried in a control frame
	localparam logic [1:0] fenceNone = 2'd0;
	localparam logic [1:0] fenceAcquire = 2'd1;
	localparam logic [1:0] fenceRelease = 2'd2;

	// A frame is either a raw instruction or a control word,
	// depending on where the scheduler is in the program
	typedef union packed {
		logic [frameWidth-1:0] insn;
		struct packed {
			logic [1:0] spare;
			logic [1:0] fence;
			logic [numCores-1:0] coreMask;
			logic [memAddrWidth-1:0] insnCount;	// Instruction frames that follow
			logic [numCores-1:0] r0Mask;
			logic [numCores*r0Width-1:0] r0Values;	// Core 0 in lowest nibble
		} ctrl;
	} taskFrame;

endpackage

//--- hw/apbTaskLoader.sv
`timescale 1ns/1ps

module apbTaskLoader (
	input logic clk,
	input logic reset,
	input logic [schedPkg::apbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	input logic busy,
	input logic [schedPkg::memAddrWidth-1:0] framePointer,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic memWrite,
	output logic [schedPkg::memAddrWidth-1:0] memWriteAddr,
	output logic [schedPkg::frameWidth-1:0] memWriteData,
	output logic launch,
	output logic [schedPkg::frameCountWidth-1:0] frameCount
);

	logic setupPhase;
	logic isFrame;
	logic isCtrl;
	logic isStatus;
	logic countOk;
	logic frameWriteOk;
	logic launchOk;
	logic statusRead;
	logic accessOk;
	logic [31:0] statusWord;

	assign pready = 1'b1;	// No wait states

	// Everything is decoded in the setup cycle so the response is ready for access
	assign setupPhase = psel & ~penable;

	assign isFrame = (paddr < schedPkg::ctrlAddr) && (paddr[1:0] == 2'b00);
	assign isCtrl = paddr == schedPkg::ctrlAddr;
	assign isStatus = paddr == schedPkg::statusAddr;

	assign countOk = (pwdata != 32'd0) && (pwdata <= schedPkg::memDepth);

	assign frameWriteOk = pwrite & isFrame & ~busy;
	assign launchOk = pwrite & isCtrl & ~busy & countOk;
	assign statusRead = ~pwrite & isStatus;
	assign accessOk = frameWriteOk | launchOk | statusRead;

	assign statusWord = {24'd0, framePointer, 3'd0, busy};

	always_ff @(posedge clk) begin
		if (reset) begin
			pslverr <= 1'b0;
			prdata <= '0;
			memWrite <= 1'b0;
			launch <= 1'b0;
			frameCount <= '0;
		end else begin
			memWrite <= setupPhase & frameWriteOk;	// Store writes at end of access
			launch <= setupPhase & launchOk;
			pslverr <= setupPhase & ~accessOk;
			if (setupPhase) begin
				prdata <= statusRead ? statusWord : 32'd0;
			end
			if (setupPhase & launchOk) begin
				frameCount <= pwdata[schedPkg::frameCountWidth-1:0];
			end
		end
	end

	// Write payload, qualified by memWrite
	always_ff @(posedge clk) begin
		if (setupPhase) begin
			memWriteAddr <= paddr[schedPkg::memAddrWidth+1:2];
			memWriteData <= pwdata;
		end
	end

endmodule

//--- hw/taskFrameStore.sv
`timescale 1ns/1ps

module taskFrameStore (
	input logic clk,
	input logic memWrite,
	input logic [schedPkg::memAddrWidth-1:0] memWriteAddr,
	input logic [schedPkg::frameWidth-1:0] memWriteData,
	input logic [schedPkg::memAddrWidth-1:0] framePointer,
	output schedPkg::taskFrame frameData
);

	logic [schedPkg::frameWidth-1:0] frames [schedPkg::memDepth];

	always_ff @(posedge clk) begin
		if (memWrite) begin
			frames[memWriteAddr] <= memWriteData;
		end
	end

	// Scheduler decides in the same cycle it points
	assign frameData = frames[framePointer];

endmodule

//--- hw/taskScheduler.sv
`timescale 1ns/1ps

module taskScheduler (
	input logic clk,
	input logic reset,
	input logic launch,
	input logic [schedPkg::frameCountWidth-1:0] frameCount,
	input schedPkg::taskFrame frameData,
	input logic [schedPkg::numCores-1:0] ready,
	output logic [schedPkg::memAddrWidth-1:0] framePointer,
	output logic busy,
	output logic [schedPkg::numCores-1:0] start,
	output logic [schedPkg::frameWidth-1:0] insnData,
	output logic [schedPkg::numCores-1:0] initR0Valid,
	output logic [schedPkg::numCores*schedPkg::r0Width-1:0] initR0
);

	logic [schedPkg::frameCountWidth-1:0] frameIndex;	// One wider than the pointer
	logic [schedPkg::memAddrWidth-1:0] remaining;
	logic [schedPkg::numCores-1:0] activeMask;
	logic [1:0] fence;

	logic pending;
	logic isCtrl;
	logic allReady;
	logic wholeCluster;
	logic maskReady;
	logic activeReady;
	logic ctrlAccept;
	logic insnIssue;

	assign framePointer = frameIndex[schedPkg::memAddrWidth-1:0];

	assign pending = busy && (frameIndex < frameCount);
	assign isCtrl = remaining == '0;	// Next frame is a control frame

	assign allReady = &ready;
	assign maskReady = (ready & frameData.ctrl.coreMask) == frameData.ctrl.coreMask;
	assign activeReady = (ready & activeMask) == activeMask;

	// Acquire from the last group or release on this one waits for the whole cluster
	assign wholeCluster = (fence == schedPkg::fenceAcquire) ||
		(frameData.ctrl.fence == schedPkg::fenceRelease);

	assign ctrlAccept = pending & isCtrl & (wholeCluster ? allReady : maskReady);
	assign insnIssue = pending & ~isCtrl & activeReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			frameIndex <= '0;
			remaining <= '0;
			activeMask <= '0;
			fence <= schedPkg::fenceNone;
			start <= '0;
			initR0Valid <= '0;
			insnData <= '0;
		end else begin
			start <= insnIssue ? activeMask : '0;
			initR0Valid <= ctrlAccept ? frameData.ctrl.r0Mask : '0;
			if (insnIssue) begin
				insnData <= frameData.insn;
			end

			if (launch & ~busy) begin
				busy <= 1'b1;
				frameIndex <= '0;
				remaining <= '0;
				fence <= schedPkg::fenceNone;	// New program starts unfenced
			end else if (busy) begin
				if (ctrlAccept | insnIssue) begin
					frameIndex <= frameIndex + 1'b1;
				end

				if (ctrlAccept) begin
					activeMask <= frameData.ctrl.coreMask;
					fence <= frameData.ctrl.fence;
					remaining <= frameData.ctrl.insnCount;
				end else if (insnIssue) begin
					remaining <= remaining - 1'b1;
				end

				// A start still in flight means its core is about to go busy
				if (~pending && allReady && (start == '0)) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// R0 values are qualified by initR0Valid
	always_ff @(posedge clk) begin
		if (ctrlAccept) begin
			initR0 <= frameData.ctrl.r0Values;
		end
	end

endmodule

//--- hw/schedTop.sv
`timescale 1ns/1ps

module schedTop (
	input logic clk,
	input logic reset,
	input logic [schedPkg::apbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic [schedPkg::numCores-1:0] ready,
	output logic [schedPkg::numCores-1:0] start,
	output logic [schedPkg::frameWidth-1:0] insnData,
	output logic [schedPkg::numCores-1:0] initR0Valid,
	output logic [schedPkg::numCores*schedPkg::r0Width-1:0] initR0
);

	logic memWrite;
	logic [schedPkg::memAddrWidth-1:0] memWriteAddr;
	logic [schedPkg::frameWidth-1:0] memWriteData;
	logic launch;
	logic [schedPkg::frameCountWidth-1:0] frameCount;
	logic [schedPkg::memAddrWidth-1:0] framePointer;
	logic busy;
	schedPkg::taskFrame frameData;

	apbTaskLoader loader (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.busy(busy),
		.framePointer(framePointer),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.memWrite(memWrite),
		.memWriteAddr(memWriteAddr),
		.memWriteData(memWriteData),
		.launch(launch),
		.frameCount(frameCount)
	);

	taskFrameStore store (
		.clk(clk),
		.memWrite(memWrite),
		.memWriteAddr(memWriteAddr),
		.memWriteData(memWriteData),
		.framePointer(framePointer),
		.frameData(frameData)
	);

	taskScheduler scheduler (
		.clk(clk),
		.reset(reset),
		.launch(launch),
		.frameCount(frameCount),
		.frameData(frameData),
		.ready(ready),
		.framePointer(framePointer),
		.busy(busy),
		.start(start),
		.insnData(insnData),
		.initR0Valid(initR0Valid),
		.initR0(initR0)
	);

endmodule

//--- bench/schedTop_checker.sv
`timescale 1ns/1ps

module schedTop_checker (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pslverr,
	input logic [schedPkg::numCores-1:0] ready,
	input logic [schedPkg::numCores-1:0] start,
	input logic [schedPkg::numCores-1:0] activeMask,
	input logic busy
);

	int failCount = 0;	// Read by the testbench at the end

	// A core only gets work it said it could take
	startAfterReady: assert property (@(posedge clk) disable iff (reset)
		(start & ~$past(ready)) == '0)
	else begin
		$error("start pulse to a core that was not ready in the previous cycle");
		failCount++;
	end

	startInGroup: assert property (@(posedge clk) disable iff (reset)
		(start & ~activeMask) == '0)
	else begin
		$error("start pulse to a core outside the active mask");
		failCount++;
	end

	startWhileBusy: assert property (@(posedge clk) disable iff (reset)
		start != '0 |-> busy)
	else begin
		$error("start pulse while the scheduler is idle");
		failCount++;
	end

	errorInAccess: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> psel && penable)
	else begin
		$error("pslverr high outside an APB access cycle");
		failCount++;
	end

endmodule

bind schedTop schedTop_checker chk (
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.ready(ready),
	.start(start),
	.activeMask(scheduler.activeMask),
	.busy(busy)
);

//--- bench/schedTb.sv
`timescale 1ns/1ps

module schedTb;

	logic clk;
	logic reset;
	logic [schedPkg::apbAddrWidth-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [schedPkg::numCores-1:0] ready;
	logic [schedPkg::numCores-1:0] start;
	logic [schedPkg::frameWidth-1:0] insnData;
	logic [schedPkg::numCores-1:0] initR0Valid;
	logic [schedPkg::numCores*schedPkg::r0Width-1:0] initR0;

	logic [31:0] lfsrState;
	int busyCycles [schedPkg::numCores];
	int errorCount;
	logic [schedPkg::frameWidth-1:0] progFrames [schedPkg::memDepth];
	int progLen;

	// Pulses the program should produce, oldest first
	logic expIsStart [$];
	logic [schedPkg::numCores-1:0] expMask [$];
	logic [31:0] expData [$];
	logic expFenced [$];
	logic [schedPkg::numCores-1:0] expOverlap [$];

	schedTop u_dut (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.ready(ready),
		.start(start),
		.insnData(insnData),
		.initR0Valid(initR0Valid),
		.initR0(initR0)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	task automatic drawDelay(output int cycles);
		logic [2:0] bits;
		int i;
		for (i = 0; i < 3; i++) begin
			lfsrState = lfsrNext(lfsrState);
			bits[i] = lfsrState[0];
		end
		cycles = int'(bits) + 1;	// 1 to 8
	endtask

	task automatic reportMismatch(input string msg);
		errorCount++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	task automatic printCounts();
		$display("Errors: %0d in testbench checks, %0d in assertions",
			errorCount, u_dut.chk.failCount);
	endtask

	task automatic abortRun(input string why);
		$display("Run stopped: %s", why);
		printCounts();
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic apbTransfer(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		@(negedge clk);
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waited = 0;
		while (!pready && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (pready) begin
			err = pslverr;
			rdata = prdata;
			@(negedge clk);
			psel = 1'b0;
			penable = 1'b0;
		end else begin
			abortRun("APB access never saw pready");
		end
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apbTransfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic addCtrl(input logic [1:0] fence, input logic [3:0] coreMask,
			input logic [3:0] insnCount, input logic [3:0] r0Mask, input logic [15:0] r0Values);
		schedPkg::taskFrame f;
		f.ctrl.spare = 2'b00;
		f.ctrl.fence = fence;
		f.ctrl.coreMask = coreMask;
		f.ctrl.insnCount = insnCount;
		f.ctrl.r0Mask = r0Mask;
		f.ctrl.r0Values = r0Values;
		progFrames[progLen] = f.insn;
		progLen++;
	endtask

	task automatic addInsn(input logic [31:0] insn);
		progFrames[progLen] = insn;
		progLen++;
	endtask

	task automatic pushEvent(input logic isStart, input logic [3:0] mask,
			input logic [31:0] data, input logic fenced);
		expIsStart.push_back(isStart);
		expMask.push_back(mask);
		expData.push_back(data);
		expFenced.push_back(fenced);
		expOverlap.push_back('0);
	endtask

	task automatic popEvent();
		void'(expIsStart.pop_front());
		void'(expMask.pop_front());
		void'(expData.pop_front());
		void'(expFenced.pop_front());
		void'(expOverlap.pop_front());
	endtask

	// Walks the program the way the frames are defined
	task automatic buildExpected();
		schedPkg::taskFrame f;
		logic [1:0] lastFence;
		logic [3:0] groupMask;
		logic fenced;
		int left;
		int i;
		lastFence = schedPkg::fenceNone;
		groupMask = '0;
		left = 0;
		for (i = 0; i < progLen; i++) begin
			f = progFrames[i];
			if (left == 0) begin
				fenced = (lastFence == schedPkg::fenceAcquire) ||
					(f.ctrl.fence == schedPkg::fenceRelease);
				if (f.ctrl.r0Mask != '0) begin
					pushEvent(1'b0, f.ctrl.r0Mask, {16'd0, f.ctrl.r0Values}, fenced);
				end
				groupMask = f.ctrl.coreMask;
				left = f.ctrl.insnCount;
				lastFence = f.ctrl.fence;
			end else begin
				pushEvent(1'b1, groupMask, f.insn, fenced);	// Fenced group keeps others idle
				left--;
			end
		end
	endtask

	task automatic loadAndLaunch(input int overlapIndex, input logic [3:0] overlapMask);
		logic err;
		int i;
		for (i = 0; i < progLen; i++) begin
			apbWrite(8'(i * 4), progFrames[i], err);
			assert (!err) else reportMismatch("frame write was refused while idle");
		end
		buildExpected();
		if (overlapIndex >= 0) begin
			expOverlap[overlapIndex] = overlapMask;
		end
		apbWrite(schedPkg::ctrlAddr, 32'(progLen), err);
		assert (!err) else reportMismatch("launch was refused");
	endtask

	task automatic waitIdle(output logic [31:0] status);
		logic err;
		int polls;
		polls = 0;
		apbRead(schedPkg::statusAddr, status, err);
		while (status[0] && polls < 200) begin
			apbRead(schedPkg::statusAddr, status, err);
			polls++;
		end
		if (status[0]) begin
			abortRun("scheduler still busy after 200 status polls");
		end
	endtask

	task automatic checkFinished();
		logic [31:0] status;
		waitIdle(status);
		assert (status[7:4] == progLen[3:0])
			else reportMismatch($sformatf("status pointer %0d, expected %0d", status[7:4], progLen));
		assert (expIsStart.size() == 0)
			else reportMismatch($sformatf("%0d expected pulses never came", expIsStart.size()));
	endtask

	// ready here is still the value the DUT decided on
	task automatic checkPulse(input logic isStart, input logic [3:0] mask, input logic [31:0] data);
		string what;
		what = isStart ? "start" : "initR0Valid";
		if (mask != '0) begin
			assert (expIsStart.size() != 0)
				else reportMismatch($sformatf("%s pulse beyond the program", what));
			if (expIsStart.size() != 0) begin
				assert (expIsStart[0] == isStart)
					else reportMismatch($sformatf("%s pulse out of program order", what));
				assert (mask == expMask[0])
					else reportMismatch($sformatf("%s mask %b, expected %b", what, mask, expMask[0]));
				assert (data == expData[0])
					else reportMismatch($sformatf("%s data %h, expected %h", what, data, expData[0]));
				assert (!expFenced[0] || ready == '1)
					else reportMismatch("fenced group accepted while a core was busy");
				assert (expOverlap[0] == '0 || (ready & expOverlap[0]) != expOverlap[0])
					else reportMismatch("second group waited for the first group to finish");
				popEvent();
			end
		end
	endtask

	always @(negedge clk) begin : coreModel
		int core;
		if (!reset) begin
			checkPulse(1'b0, initR0Valid, {16'd0, initR0});
			checkPulse(1'b1, start, insnData);
			for (core = 0; core < schedPkg::numCores; core++) begin
				if (start[core]) begin
					drawDelay(busyCycles[core]);
					ready[core] = 1'b0;	// Core runs its task
				end else if (busyCycles[core] > 0) begin
					busyCycles[core]--;
					if (busyCycles[core] == 0) begin
						ready[core] = 1'b1;
					end
				end
			end
		end
	end

	initial begin
		logic [31:0] status;
		logic err;
		int core;
		clk = 1'b0;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		ready = '1;
		lfsrState = 32'h339a;
		errorCount = 0;
		progLen = 0;
		for (core = 0; core < schedPkg::numCores; core++) begin
			busyCycles[core] = 0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Five frames, second group behind a release fence
		addCtrl(schedPkg::fenceNone, 4'b0101, 4'd1, 4'b0101, 16'h0a0b);
		addInsn(32'hc0de_0001);
		addCtrl(schedPkg::fenceRelease, 4'b1010, 4'd2, 4'b1010, 16'h3c4d);
		addInsn(32'hc0de_0002);
		addInsn(32'hc0de_0003);
		loadAndLaunch(-1, '0);
		apbRead(schedPkg::statusAddr, status, err);
		assert (!err && status[0]) else reportMismatch("status does not show busy after launch");
		checkFinished();

		// Disjoint groups, no fence
		progLen = 0;
		addCtrl(schedPkg::fenceNone, 4'b0011, 4'd1, 4'b0000, 16'h0000);
		addInsn(32'h1111_0001);
		addCtrl(schedPkg::fenceNone, 4'b1100, 4'd1, 4'b1100, 16'h5600);
		addInsn(32'h2222_0002);
		loadAndLaunch(2, 4'b0011);	// Group 2 starts while group 1 still runs
		checkFinished();

		// Acquire fence, plus a frame write during the run
		progLen = 0;
		addCtrl(schedPkg::fenceAcquire, 4'b1111, 4'd2, 4'b1111, 16'h4321);
		addInsn(32'h3333_0001);
		addInsn(32'h3333_0002);
		addCtrl(schedPkg::fenceNone, 4'b0001, 4'd1, 4'b0001, 16'h0009);
		addInsn(32'h3333_0003);
		loadAndLaunch(-1, '0);
		apbWrite(8'h10, 32'hdead_beef, err);	// Frame 4, not yet issued
		assert (err) else reportMismatch("frame write while busy was accepted");
		checkFinished();

		apbWrite(schedPkg::ctrlAddr, 32'd0, err);
		assert (err) else reportMismatch("count of 0 was accepted");
		apbRead(8'h00, status, err);
		assert (err) else reportMismatch("frame read did not return an error");
		apbRead(schedPkg::statusAddr, status, err);
		assert (!err && !status[0] && status[7:4] == progLen[3:0])
			else reportMismatch("count of 0 started the scheduler");

		printCounts();
		if (errorCount == 0 && u_dut.chk.failCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- vlog.f
hw/schedPkg.sv
hw/apbTaskLoader.sv
hw/taskFrameStore.sv
hw/taskScheduler.sv
hw/schedTop.sv
bench/schedTop_checker.sv
bench/schedTb.sv

//--- Bender.yml
package:
  name: sched_dispatch

sources:
  - hw/schedPkg.sv
  - hw/apbTaskLoader.sv
  - hw/taskFrameStore.sv
  - hw/taskScheduler.sv
  - hw/schedTop.sv
  - target: test
    files:
      - bench/schedTop_checker.sv
      - bench/schedTb.sv
